/* hdl/ctrl_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OpenRISC control stage shared definitions
// SPR map, SR bits, exception causes and vectors
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ctrl_pkg;

   localparam int DATA_W = 32;
   localparam int SR_W   = 16;

   // One SPR address word, routed by group and selected as a whole
   typedef union packed {
      logic [15:0] flat;
      struct packed {
         logic [4:0]  group;
         logic [10:0] index;
      } f;
   } spr_addr_u;

   localparam logic [4:0] GRP_SYS = 5'd0;
   localparam logic [4:0] GRP_PIC = 5'd9;
   localparam logic [4:0] GRP_TT  = 5'd10;

   // System group
   localparam logic [15:0] ADDR_VR    = 16'h0000;
   localparam logic [15:0] ADDR_EVBA  = 16'h000B;
   localparam logic [15:0] ADDR_SR    = 16'h0011;
   localparam logic [15:0] ADDR_EPCR0 = 16'h0020;
   localparam logic [15:0] ADDR_EEAR0 = 16'h0030;
   localparam logic [15:0] ADDR_ESR0  = 16'h0040;
   // PIC and tick timer groups
   localparam logic [15:0] ADDR_PICMR = 16'h4800;
   localparam logic [15:0] ADDR_PICSR = 16'h4802;
   localparam logic [15:0] ADDR_TTMR  = 16'h5000;
   localparam logic [15:0] ADDR_TTCR  = 16'h5001;

   localparam logic [DATA_W-1:0] VR_VALUE = 32'h1201_0001;
   localparam logic [SR_W-1:0]   SR_RESET = 16'h8001;

   localparam int SR_SM  = 0;
   localparam int SR_TEE = 1;
   localparam int SR_IEE = 2;

   typedef enum logic [2:0] {
      CAUSE_ILLEGAL,
      CAUSE_ALIGN,
      CAUSE_SYSCALL,
      CAUSE_TRAP,
      CAUSE_INT,
      CAUSE_TICK
   } cause_e;

   // Vector offsets, OR'ed onto EVBA
   localparam logic [DATA_W-1:0] VEC_TICK    = 32'h0000_0500;
   localparam logic [DATA_W-1:0] VEC_ALIGN   = 32'h0000_0600;
   localparam logic [DATA_W-1:0] VEC_ILLEGAL = 32'h0000_0700;
   localparam logic [DATA_W-1:0] VEC_INT     = 32'h0000_0800;
   localparam logic [DATA_W-1:0] VEC_SYSCALL = 32'h0000_0C00;
   localparam logic [DATA_W-1:0] VEC_TRAP    = 32'h0000_0E00;

   localparam int EVBA_LOW_BITS = 13;

endpackage

/* hdl/spr_bus_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPR access port with single-beat stb/ack handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module spr_bus_ctrl (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        stb_i,
   input  logic                        we_i,
   input  logic [15:0]                 addr_i,
   input  logic [ctrl_pkg::DATA_W-1:0] dat_i,
   input  logic [ctrl_pkg::DATA_W-1:0] sys_rdat_i,
   input  logic [ctrl_pkg::DATA_W-1:0] tt_rdat_i,
   input  logic [ctrl_pkg::DATA_W-1:0] pic_rdat_i,
   output logic                        ack_o,
   output logic [ctrl_pkg::DATA_W-1:0] rdat_o,
   output ctrl_pkg::spr_addr_u         addr_o,
   output logic [ctrl_pkg::DATA_W-1:0] wdat_o,
   output logic                        sys_we_o,
   output logic                        tt_we_o,
   output logic                        pic_we_o
);

   logic                        access;
   logic                        wr;
   logic [ctrl_pkg::DATA_W-1:0] rsel;

   assign addr_o.flat = addr_i;
   assign wdat_o      = dat_i;

   // Strobe seen and not yet acked, ack rises at the next edge
   assign access = stb_i & ~ack_o;
   assign wr     = access & we_i;

   assign sys_we_o = wr & (addr_o.f.group == ctrl_pkg::GRP_SYS);
   assign pic_we_o = wr & (addr_o.f.group == ctrl_pkg::GRP_PIC);
   assign tt_we_o  = wr & (addr_o.f.group == ctrl_pkg::GRP_TT);

   // Unmapped groups read as zero
   always_comb begin
      case (addr_o.f.group)
         ctrl_pkg::GRP_SYS: rsel = sys_rdat_i;
         ctrl_pkg::GRP_PIC: rsel = pic_rdat_i;
         ctrl_pkg::GRP_TT:  rsel = tt_rdat_i;
         default:           rsel = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst)
         ack_o <= 1'b0;
      else
         ack_o <= access;
   end

   always_ff @(posedge clk) begin
      if (access)
         rdat_o <= rsel;
   end

endmodule

/* hdl/exception_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Exception and l.rfe arbiter
// Picks the cause by priority and branches fetch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module exception_ctrl (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        except_illegal_i,
   input  logic                        except_align_i,
   input  logic                        except_syscall_i,
   input  logic                        except_trap_i,
   input  logic                        rfe_i,
   input  logic                        fetch_branch_taken_i,
   input  logic                        tick_irq_i,
   input  logic                        pic_irq_i,
   input  logic                        sr_tee_i,
   input  logic                        sr_iee_i,
   input  logic [ctrl_pkg::DATA_W-1:0] evba_i,
   input  logic [ctrl_pkg::DATA_W-1:0] epcr_i,
   output logic                        enter_o,
   output ctrl_pkg::cause_e            cause_o,
   output logic                        rfe_do_o,
   output logic                        branch_o,
   output logic [ctrl_pkg::DATA_W-1:0] branch_pc_o
);

   localparam logic [1:0] ST_IDLE   = 2'd0;
   localparam logic [1:0] ST_BRANCH = 2'd1;
   localparam logic [1:0] ST_SETTLE = 2'd2;

   logic [1:0]                  state;
   logic                        tick_req;
   logic                        int_req;
   logic                        exc_req;
   logic [ctrl_pkg::DATA_W-1:0] vec;

   // Interrupts only count when enabled in SR
   assign tick_req = tick_irq_i & sr_tee_i;
   assign int_req  = pic_irq_i & sr_iee_i;
   assign exc_req  = except_illegal_i | except_align_i | except_syscall_i |
                     except_trap_i | int_req | tick_req;

   always_comb begin
      if (except_illegal_i)
         cause_o = ctrl_pkg::CAUSE_ILLEGAL;
      else if (except_align_i)
         cause_o = ctrl_pkg::CAUSE_ALIGN;
      else if (except_syscall_i)
         cause_o = ctrl_pkg::CAUSE_SYSCALL;
      else if (except_trap_i)
         cause_o = ctrl_pkg::CAUSE_TRAP;
      else if (int_req)
         cause_o = ctrl_pkg::CAUSE_INT;
      else
         cause_o = ctrl_pkg::CAUSE_TICK;
   end

   always_comb begin
      case (cause_o)
         ctrl_pkg::CAUSE_ILLEGAL: vec = ctrl_pkg::VEC_ILLEGAL;
         ctrl_pkg::CAUSE_ALIGN:   vec = ctrl_pkg::VEC_ALIGN;
         ctrl_pkg::CAUSE_SYSCALL: vec = ctrl_pkg::VEC_SYSCALL;
         ctrl_pkg::CAUSE_TRAP:    vec = ctrl_pkg::VEC_TRAP;
         ctrl_pkg::CAUSE_INT:     vec = ctrl_pkg::VEC_INT;
         default:                 vec = ctrl_pkg::VEC_TICK;
      endcase
   end

   // Exceptions win over l.rfe in the same cycle
   assign enter_o  = (state == ST_IDLE) & exc_req;
   assign rfe_do_o = (state == ST_IDLE) & ~exc_req & rfe_i;
   assign branch_o = (state == ST_BRANCH);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE:   if (enter_o | rfe_do_o) state <= ST_BRANCH;
            ST_BRANCH: if (fetch_branch_taken_i) state <= ST_SETTLE;
            default:   state <= ST_IDLE;
         endcase
      end
   end

   // Target held for the whole branch
   always_ff @(posedge clk) begin
      if (enter_o)
         branch_pc_o <= evba_i | vec;
      else if (rfe_do_o)
         branch_pc_o <= epcr_i;
   end

endmodule

/* hdl/sys_spr_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// System group SPRs: SR, ESR, EPCR, EEAR, EVBA, VR
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sys_spr_regs #(
   parameter logic [31:0] RESET_PC = 32'h0000_0100
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        we_i,
   input  ctrl_pkg::spr_addr_u         addr_i,
   input  logic [ctrl_pkg::DATA_W-1:0] dat_i,
   input  logic                        enter_i,
   input  ctrl_pkg::cause_e            cause_i,
   input  logic                        rfe_do_i,
   input  logic [ctrl_pkg::DATA_W-1:0] pc_i,
   input  logic [ctrl_pkg::DATA_W-1:0] fault_addr_i,
   output logic [ctrl_pkg::DATA_W-1:0] rdat_o,
   output logic [ctrl_pkg::SR_W-1:0]   sr_o,
   output logic [ctrl_pkg::DATA_W-1:0] evba_o,
   output logic [ctrl_pkg::DATA_W-1:0] epcr_o
);

   logic [ctrl_pkg::SR_W-1:0]   esr;
   logic [ctrl_pkg::DATA_W-1:0] eear;
   logic                        pc_this;

   // Faulting instructions restart, the rest resume after
   assign pc_this = (cause_i == ctrl_pkg::CAUSE_ILLEGAL) |
                    (cause_i == ctrl_pkg::CAUSE_ALIGN) |
                    (cause_i == ctrl_pkg::CAUSE_TRAP);

   always_ff @(posedge clk) begin
      if (rst) begin
         sr_o <= ctrl_pkg::SR_RESET;
      end else if (enter_i) begin
         sr_o[ctrl_pkg::SR_SM]  <= 1'b1;
         sr_o[ctrl_pkg::SR_TEE] <= 1'b0;
         sr_o[ctrl_pkg::SR_IEE] <= 1'b0;
      end else if (rfe_do_i) begin
         sr_o <= esr;
      end else if (we_i && addr_i.flat == ctrl_pkg::ADDR_SR && sr_o[ctrl_pkg::SR_SM]) begin
         sr_o <= dat_i[ctrl_pkg::SR_W-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         esr    <= ctrl_pkg::SR_RESET;
         epcr_o <= RESET_PC;
         eear   <= '0;
      end else if (enter_i) begin
         esr    <= sr_o;
         epcr_o <= pc_this ? pc_i : pc_i + 32'd4;
         eear   <= (cause_i == ctrl_pkg::CAUSE_ALIGN) ? fault_addr_i : pc_i;
      end else if (we_i) begin
         if (addr_i.flat == ctrl_pkg::ADDR_ESR0)
            esr <= dat_i[ctrl_pkg::SR_W-1:0];
         if (addr_i.flat == ctrl_pkg::ADDR_EPCR0)
            epcr_o <= dat_i;
         if (addr_i.flat == ctrl_pkg::ADDR_EEAR0)
            eear <= dat_i;
      end
   end

   // Vector base keeps its low bits clear
   always_ff @(posedge clk) begin
      if (rst)
         evba_o <= '0;
      else if (we_i && addr_i.flat == ctrl_pkg::ADDR_EVBA)
         evba_o <= {dat_i[ctrl_pkg::DATA_W-1:ctrl_pkg::EVBA_LOW_BITS],
                    {ctrl_pkg::EVBA_LOW_BITS{1'b0}}};
   end

   always_comb begin
      case (addr_i.flat)
         ctrl_pkg::ADDR_VR:    rdat_o = ctrl_pkg::VR_VALUE;
         ctrl_pkg::ADDR_EVBA:  rdat_o = evba_o;
         ctrl_pkg::ADDR_SR:    rdat_o = {{(ctrl_pkg::DATA_W-ctrl_pkg::SR_W){1'b0}}, sr_o};
         ctrl_pkg::ADDR_EPCR0: rdat_o = epcr_o;
         ctrl_pkg::ADDR_EEAR0: rdat_o = eear;
         ctrl_pkg::ADDR_ESR0:  rdat_o = {{(ctrl_pkg::DATA_W-ctrl_pkg::SR_W){1'b0}}, esr};
         default:              rdat_o = '0;
      endcase
   end

endmodule

/* hdl/tick_timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tick timer, TTMR mode/period and TTCR counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tick_timer (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        we_i,
   input  ctrl_pkg::spr_addr_u         addr_i,
   input  logic [ctrl_pkg::DATA_W-1:0] dat_i,
   output logic [ctrl_pkg::DATA_W-1:0] rdat_o,
   output logic                        irq_o
);

   logic [ctrl_pkg::DATA_W-1:0] ttmr;
   logic [ctrl_pkg::DATA_W-1:0] ttcr;
   logic [1:0]                  mode;
   logic                        hit;

   assign mode  = ttmr[31:30];
   assign hit   = (mode != 2'b00) & (ttcr[27:0] == ttmr[27:0]);
   assign irq_o = ttmr[28];

   always_ff @(posedge clk) begin
      if (rst) begin
         ttmr <= '0;
      end else begin
         // IP can only be cleared by software
         if (we_i && addr_i.flat == ctrl_pkg::ADDR_TTMR)
            ttmr <= {dat_i[31:29], dat_i[28] & ttmr[28], dat_i[27:0]};
         if (hit & ttmr[29])
            ttmr[28] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst)
         ttcr <= '0;
      else if (we_i && addr_i.flat == ctrl_pkg::ADDR_TTCR)
         ttcr <= dat_i;
      else if (hit && mode == 2'b01)
         ttcr <= '0;
      else if (mode != 2'b00 && !(hit && mode == 2'b10))
         ttcr <= ttcr + 32'd1;
   end

   always_comb begin
      case (addr_i.flat)
         ctrl_pkg::ADDR_TTMR: rdat_o = ttmr;
         ctrl_pkg::ADDR_TTCR: rdat_o = ttcr;
         default:             rdat_o = '0;
      endcase
   end

endmodule

/* hdl/pic.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Edge-triggered interrupt controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pic (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        we_i,
   input  ctrl_pkg::spr_addr_u         addr_i,
   input  logic [ctrl_pkg::DATA_W-1:0] dat_i,
   input  logic [31:0]                 irq_i,
   output logic [ctrl_pkg::DATA_W-1:0] rdat_o,
   output logic                        irq_o
);

   logic [31:0] irq_q;
   logic [31:0] picmr;
   logic [31:0] picsr;
   logic [31:0] clr;

   // Write-one-to-clear on PICSR
   assign clr   = (we_i && addr_i.flat == ctrl_pkg::ADDR_PICSR) ? dat_i : '0;
   assign irq_o = |picsr;

   always_ff @(posedge clk) begin
      if (rst) begin
         irq_q <= '0;
         picmr <= '0;
         picsr <= '0;
      end else begin
         irq_q <= irq_i;
         if (we_i && addr_i.flat == ctrl_pkg::ADDR_PICMR)
            picmr <= dat_i;
         picsr <= (picsr & ~clr) | (irq_i & ~irq_q & picmr);
      end
   end

   assign rdat_o = (addr_i.flat == ctrl_pkg::ADDR_PICMR) ? picmr :
                   (addr_i.flat == ctrl_pkg::ADDR_PICSR) ? picsr : '0;

endmodule

/* hdl/or1k_ctrl_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OpenRISC exception and SPR control unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module or1k_ctrl_unit #(
   parameter logic [31:0] RESET_PC = 32'h0000_0100
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        spr_stb_i,
   input  logic                        spr_we_i,
   input  logic [15:0]                 spr_addr_i,
   input  logic [ctrl_pkg::DATA_W-1:0] spr_dat_i,
   input  logic                        except_illegal_i,
   input  logic                        except_align_i,
   input  logic                        except_syscall_i,
   input  logic                        except_trap_i,
   input  logic                        rfe_i,
   input  logic [ctrl_pkg::DATA_W-1:0] pc_i,
   input  logic [ctrl_pkg::DATA_W-1:0] fault_addr_i,
   input  logic                        fetch_branch_taken_i,
   input  logic [31:0]                 irq_i,
   output logic [ctrl_pkg::DATA_W-1:0] spr_dat_o,
   output logic                        spr_ack_o,
   output logic                        branch_o,
   output logic [ctrl_pkg::DATA_W-1:0] branch_pc_o,
   output logic [ctrl_pkg::SR_W-1:0]   sr_o
);

   ctrl_pkg::spr_addr_u         spr_addr;
   logic [ctrl_pkg::DATA_W-1:0] spr_wdat;
   logic [ctrl_pkg::DATA_W-1:0] sys_rdat;
   logic [ctrl_pkg::DATA_W-1:0] tt_rdat;
   logic [ctrl_pkg::DATA_W-1:0] pic_rdat;
   logic                        sys_we;
   logic                        tt_we;
   logic                        pic_we;
   logic                        tick_irq;
   logic                        pic_irq;
   logic                        enter;
   logic                        rfe_do;
   ctrl_pkg::cause_e            cause;
   logic [ctrl_pkg::DATA_W-1:0] evba;
   logic [ctrl_pkg::DATA_W-1:0] epcr;

   spr_bus_ctrl spr_bus_ctrl_inst (
      .clk(clk), .rst(rst),
      .stb_i(spr_stb_i), .we_i(spr_we_i), .addr_i(spr_addr_i), .dat_i(spr_dat_i),
      .sys_rdat_i(sys_rdat), .tt_rdat_i(tt_rdat), .pic_rdat_i(pic_rdat),
      .ack_o(spr_ack_o), .rdat_o(spr_dat_o), .addr_o(spr_addr), .wdat_o(spr_wdat),
      .sys_we_o(sys_we), .tt_we_o(tt_we), .pic_we_o(pic_we)
   );

   exception_ctrl exception_ctrl_inst (
      .clk(clk), .rst(rst),
      .except_illegal_i(except_illegal_i), .except_align_i(except_align_i),
      .except_syscall_i(except_syscall_i), .except_trap_i(except_trap_i),
      .rfe_i(rfe_i), .fetch_branch_taken_i(fetch_branch_taken_i),
      .tick_irq_i(tick_irq), .pic_irq_i(pic_irq),
      .sr_tee_i(sr_o[ctrl_pkg::SR_TEE]), .sr_iee_i(sr_o[ctrl_pkg::SR_IEE]),
      .evba_i(evba), .epcr_i(epcr),
      .enter_o(enter), .cause_o(cause), .rfe_do_o(rfe_do),
      .branch_o(branch_o), .branch_pc_o(branch_pc_o)
   );

   sys_spr_regs #(.RESET_PC(RESET_PC)) sys_spr_regs_inst (
      .clk(clk), .rst(rst),
      .we_i(sys_we), .addr_i(spr_addr), .dat_i(spr_wdat),
      .enter_i(enter), .cause_i(cause), .rfe_do_i(rfe_do),
      .pc_i(pc_i), .fault_addr_i(fault_addr_i),
      .rdat_o(sys_rdat), .sr_o(sr_o), .evba_o(evba), .epcr_o(epcr)
   );

   tick_timer tick_timer_inst (
      .clk(clk), .rst(rst),
      .we_i(tt_we), .addr_i(spr_addr), .dat_i(spr_wdat),
      .rdat_o(tt_rdat), .irq_o(tick_irq)
   );

   pic pic_inst (
      .clk(clk), .rst(rst),
      .we_i(pic_we), .addr_i(spr_addr), .dat_i(spr_wdat), .irq_i(irq_i),
      .rdat_o(pic_rdat), .irq_o(pic_irq)
   );

endmodule

/* test/tb_ref.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model for the control unit testbench
// Vectors, entry state, timer and PIC updates
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_REF_SVH
`define TB_REF_SVH

// Request bits: 0 illegal, 1 align, 2 syscall, 3 trap, 4 int, 5 tick
function automatic int top_cause(input logic [5:0] req);
   int i;
   top_cause = 5;
   for (i = 5; i >= 0; i--) begin
      if (req[i])
         top_cause = i;
   end
endfunction

function automatic logic [31:0] expected_vector(input logic [5:0] req,
                                                input logic [31:0] evba);
   logic [31:0] vec;
   case (top_cause(req))
      0: vec = ctrl_pkg::VEC_ILLEGAL;
      1: vec = ctrl_pkg::VEC_ALIGN;
      2: vec = ctrl_pkg::VEC_SYSCALL;
      3: vec = ctrl_pkg::VEC_TRAP;
      4: vec = ctrl_pkg::VEC_INT;
      default: vec = ctrl_pkg::VEC_TICK;
   endcase
   return evba | vec;
endfunction

// Illegal, align and trap restart the instruction
function automatic logic [31:0] expected_epcr(input logic [5:0] req, input logic [31:0] pc);
   int c;
   c = top_cause(req);
   if (c == 0 || c == 1 || c == 3)
      return pc;
   return pc + 32'd4;
endfunction

function automatic logic [31:0] expected_eear(input logic [5:0] req, input logic [31:0] pc,
                                              input logic [31:0] fault);
   return (top_cause(req) == 1) ? fault : pc;
endfunction

// SM set, TEE and IEE cleared
function automatic logic [15:0] sr_after_entry(input logic [15:0] sr);
   return (sr | 16'h0001) & ~16'h0006;
endfunction

function automatic logic [31:0] ttmr_after_hit(input logic [31:0] ttmr);
   return ttmr[29] ? (ttmr | 32'h1000_0000) : ttmr;
endfunction

function automatic logic [31:0] picsr_after_edge(input logic [31:0] picsr,
                                                 input logic [31:0] mask, input int line);
   return picsr | (mask & (32'h1 << line));
endfunction

function automatic logic [31:0] evba_stored(input logic [31:0] v);
   return v & ~32'h0000_1FFF;
endfunction

`endif

/* test/tb_or1k_ctrl_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the OpenRISC exception/SPR unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_or1k_ctrl_unit;

   localparam int CLK_PERIOD = 40;
   localparam int NUM_TESTS  = 6;

   logic        clk = 1'b0;
   logic        rst;
   logic        spr_stb_i;
   logic        spr_we_i;
   logic [15:0] spr_addr_i;
   logic [31:0] spr_dat_i;
   logic        except_illegal_i;
   logic        except_align_i;
   logic        except_syscall_i;
   logic        except_trap_i;
   logic        rfe_i;
   logic [31:0] pc_i;
   logic [31:0] fault_addr_i;
   logic        fetch_branch_taken_i;
   logic [31:0] irq_i;
   logic [31:0] spr_dat_o;
   logic        spr_ack_o;
   logic        branch_o;
   logic [31:0] branch_pc_o;
   logic [15:0] sr_o;

   integer      seed = 32'he5dc;
   string       test_name;
   int          errors_at_start;
   int          errors = 0;
   int          other_errors = 0;
   int          checks = 0;
   int          tests_done = 0;
   string       name_q[$];
   logic [31:0] exp_q[$];
   logic [31:0] act_q[$];
   event        check_ev;
   logic [31:0] evba_exp;

   `include "tb_ref.svh"

   or1k_ctrl_unit #(.RESET_PC(32'h0000_0100)) or1k_ctrl_unit_inst (
      .clk(clk), .rst(rst),
      .spr_stb_i(spr_stb_i), .spr_we_i(spr_we_i),
      .spr_addr_i(spr_addr_i), .spr_dat_i(spr_dat_i),
      .except_illegal_i(except_illegal_i), .except_align_i(except_align_i),
      .except_syscall_i(except_syscall_i), .except_trap_i(except_trap_i),
      .rfe_i(rfe_i), .pc_i(pc_i), .fault_addr_i(fault_addr_i),
      .fetch_branch_taken_i(fetch_branch_taken_i), .irq_i(irq_i),
      .spr_dat_o(spr_dat_o), .spr_ack_o(spr_ack_o),
      .branch_o(branch_o), .branch_pc_o(branch_pc_o), .sr_o(sr_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Drains queued results and compares them
   initial begin : compare
      string       cname;
      logic [31:0] cexp;
      logic [31:0] cact;
      forever begin
         @(check_ev);
         while (name_q.size() > 0) begin
            cname = name_q.pop_front();
            cexp  = exp_q.pop_front();
            cact  = act_q.pop_front();
            checks++;
            if (cact !== cexp) begin
               errors++;
               $display("ERR %s: expected %h actual %h", cname, cexp, cact);
            end
         end
      end
   end

   // Fetch takes the branch 1 to 4 cycles after seeing it
   initial begin : fetch_model
      int lat;
      fetch_branch_taken_i = 1'b0;
      forever begin
         @(negedge clk);
         if (branch_o) begin
            lat = 1 + ($random(seed) & 3);
            repeat (lat - 1) @(negedge clk);
            fetch_branch_taken_i = 1'b1;
            @(negedge clk);
            fetch_branch_taken_i = 1'b0;
         end
      end
   end

   initial begin : watchdog
      #(NUM_TESTS * 2000 * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d ns", NUM_TESTS * 2000 * CLK_PERIOD);
      $display("RESULT: FAIL");
      $finish;
   end

   task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
      name_q.push_back({test_name, " ", what});
      exp_q.push_back(exp);
      act_q.push_back(act);
      -> check_ev;
   endtask

   task automatic report_failure(input string msg);
      other_errors++;
      $display("Test %s: %s", test_name, msg);
   endtask

   task automatic start_test(input string name);
      test_name       = name;
      errors_at_start = errors + other_errors;
   endtask

   task automatic end_test();
      @(negedge clk);
      tests_done++;
      if (errors + other_errors == errors_at_start)
         $display("Test %s: passed", test_name);
      else
         $display("Test %s: failed with %0d errors", test_name,
                  errors + other_errors - errors_at_start);
   endtask

   // Single-beat access, strobe held until ack
   task automatic spr_access(input logic we, input logic [15:0] addr, input logic [31:0] data,
                             output logic [31:0] rdata);
      int n;
      n          = 0;
      spr_stb_i  = 1'b1;
      spr_we_i   = we;
      spr_addr_i = addr;
      spr_dat_i  = data;
      do begin
         @(negedge clk);
         n++;
      end while (!spr_ack_o && n < 20);
      if (!spr_ack_o)
         report_failure($sformatf("no ack for access to SPR %h", addr));
      rdata     = spr_dat_o;
      spr_stb_i = 1'b0;
      spr_we_i  = 1'b0;
      @(negedge clk);
   endtask

   task automatic spr_write(input logic [15:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      spr_access(1'b1, addr, data, unused);
   endtask

   task automatic spr_read(input logic [15:0] addr, output logic [31:0] rdata);
      spr_access(1'b0, addr, 32'h0, rdata);
   endtask

   task automatic await_branch(input int limit);
      int n;
      n = 0;
      while (!branch_o && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (!branch_o)
         report_failure("branch_o did not rise");
   endtask

   task automatic await_branch_end();
      int n;
      n = 0;
      while (branch_o && n < 20) begin
         @(negedge clk);
         n++;
      end
      if (branch_o)
         report_failure("the branch was never taken by fetch");
   endtask

   task automatic watch_no_branch(input int cycles, output logic [31:0] hits);
      hits = 32'h0;
      repeat (cycles) begin
         @(negedge clk);
         hits = hits + {31'h0, branch_o};
      end
   endtask

   task automatic pulse_irq(input int line);
      irq_i[line] = 1'b1;
      @(negedge clk);
      irq_i = 32'h0;
   endtask

   initial begin : stimulus
      logic [31:0] rdata;
      logic [31:0] val;
      logic [31:0] pc;
      logic [31:0] fault;
      logic [31:0] mask;
      logic [31:0] ttmr_val;
      logic [31:0] hits;
      logic [15:0] old_sr;
      logic [15:0] esr_val;
      logic [5:0]  req;
      int          line_off;
      int          line_on;
      int          i;

      rst              = 1'b1;
      spr_stb_i        = 1'b0;
      spr_we_i         = 1'b0;
      spr_addr_i       = 16'h0;
      spr_dat_i        = 32'h0;
      except_illegal_i = 1'b0;
      except_align_i   = 1'b0;
      except_syscall_i = 1'b0;
      except_trap_i    = 1'b0;
      rfe_i            = 1'b0;
      pc_i             = 32'h0;
      fault_addr_i     = 32'h0;
      irq_i            = 32'h0;
      repeat (4) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);

      start_test("reset");
      expect_eq("branch_o", 32'h0, {31'h0, branch_o});
      expect_eq("ack", 32'h0, {31'h0, spr_ack_o});
      spr_read(ctrl_pkg::ADDR_SR, rdata);
      expect_eq("SR", 32'h0000_8001, rdata);
      spr_read(ctrl_pkg::ADDR_VR, rdata);
      expect_eq("VR", ctrl_pkg::VR_VALUE, rdata);
      spr_read(ctrl_pkg::ADDR_EVBA, rdata);
      expect_eq("EVBA", 32'h0, rdata);
      spr_read(ctrl_pkg::ADDR_PICSR, rdata);
      expect_eq("PICSR", 32'h0, rdata);
      spr_read({5'd3, 11'($random(seed))}, rdata);
      expect_eq("unmapped", 32'h0, rdata);
      end_test();

      start_test("write_read");
      val      = $random(seed);
      evba_exp = evba_stored(val);
      spr_write(ctrl_pkg::ADDR_EVBA, val);
      spr_read(ctrl_pkg::ADDR_EVBA, rdata);
      expect_eq("EVBA", evba_exp, rdata);
      val = $random(seed);
      spr_write(ctrl_pkg::ADDR_EPCR0, val);
      spr_read(ctrl_pkg::ADDR_EPCR0, rdata);
      expect_eq("EPCR", val, rdata);
      val = $random(seed);
      spr_write(ctrl_pkg::ADDR_ESR0, val);
      spr_read(ctrl_pkg::ADDR_ESR0, rdata);
      expect_eq("ESR", {16'h0, val[15:0]}, rdata);
      val = $random(seed);
      spr_write(ctrl_pkg::ADDR_PICMR, val);
      spr_read(ctrl_pkg::ADDR_PICMR, rdata);
      expect_eq("PICMR", val, rdata);
      val = $random(seed);
      spr_write(ctrl_pkg::ADDR_TTCR, val);
      spr_read(ctrl_pkg::ADDR_TTCR, rdata);
      expect_eq("TTCR", val, rdata);
      end_test();

      start_test("exception_entry");
      for (i = 0; i < 4; i++) begin
         // Random SR with SM, TEE and IEE set, no interrupt source is live
         old_sr = 16'($random(seed)) | 16'h0007;
         spr_write(ctrl_pkg::ADDR_SR, {16'h0, old_sr});
         req = {2'b00, 4'($random(seed))};
         if (req == 6'd0)
            req[i % 4] = 1'b1;
         pc       = $random(seed);
         pc[1:0]  = 2'b00;
         fault    = $random(seed);
         except_illegal_i = req[0];
         except_align_i   = req[1];
         except_syscall_i = req[2];
         except_trap_i    = req[3];
         pc_i             = pc;
         fault_addr_i     = fault;
         @(negedge clk);
         expect_eq("latency", 32'h1, {31'h0, branch_o});
         expect_eq("vector", expected_vector(req, evba_exp), branch_pc_o);
         await_branch_end();
         except_illegal_i = 1'b0;
         except_align_i   = 1'b0;
         except_syscall_i = 1'b0;
         except_trap_i    = 1'b0;
         expect_eq("SR", {16'h0, sr_after_entry(old_sr)}, {16'h0, sr_o});
         spr_read(ctrl_pkg::ADDR_EPCR0, rdata);
         expect_eq("EPCR", expected_epcr(req, pc), rdata);
         spr_read(ctrl_pkg::ADDR_EEAR0, rdata);
         expect_eq("EEAR", expected_eear(req, pc, fault), rdata);
         spr_read(ctrl_pkg::ADDR_ESR0, rdata);
         expect_eq("ESR", {16'h0, old_sr}, rdata);
      end
      end_test();

      start_test("rfe");
      // Keep SM so later SR writes still land, interrupts stay off
      esr_val = 16'($random(seed));
      esr_val = (esr_val | 16'h0001) & ~16'h0006;
      val     = $random(seed);
      spr_write(ctrl_pkg::ADDR_ESR0, {16'h0, esr_val});
      spr_write(ctrl_pkg::ADDR_EPCR0, val);
      rfe_i = 1'b1;
      @(negedge clk);
      expect_eq("latency", 32'h1, {31'h0, branch_o});
      expect_eq("target", val, branch_pc_o);
      await_branch_end();
      rfe_i = 1'b0;
      expect_eq("SR", {16'h0, esr_val}, {16'h0, sr_o});
      end_test();

      start_test("tick_timer");
      spr_write(ctrl_pkg::ADDR_SR, 32'h0000_8003);
      expect_eq("SR write", 32'h0000_8003, {16'h0, sr_o});
      pc      = $random(seed);
      pc[1:0] = 2'b00;
      pc_i    = pc;
      spr_write(ctrl_pkg::ADDR_TTCR, 32'h0);
      ttmr_val = {2'b01, 1'b1, 1'b0, 28'(4 + ($random(seed) & 15))};
      spr_write(ctrl_pkg::ADDR_TTMR, ttmr_val);
      await_branch(64);
      expect_eq("vector", expected_vector(6'b100000, evba_exp), branch_pc_o);
      await_branch_end();
      expect_eq("SR", {16'h0, sr_after_entry(16'h8003)}, {16'h0, sr_o});
      spr_read(ctrl_pkg::ADDR_EPCR0, rdata);
      expect_eq("EPCR", expected_epcr(6'b100000, pc), rdata);
      spr_read(ctrl_pkg::ADDR_TTMR, rdata);
      expect_eq("TTMR", ttmr_after_hit(ttmr_val), rdata);
      // Timer keeps running, IP comes back but TEE is clear
      spr_write(ctrl_pkg::ADDR_TTMR, ttmr_val);
      watch_no_branch(40, hits);
      expect_eq("quiet", 32'h0, hits);
      spr_write(ctrl_pkg::ADDR_TTMR, 32'h0);
      end_test();

      start_test("pic_edges");
      mask     = $random(seed);
      line_off = $random(seed) & 31;
      line_on  = (line_off + 1 + (($random(seed) & 32'h7FFF_FFFF) % 31)) % 32;
      mask[line_off] = 1'b0;
      mask[line_on]  = 1'b1;
      spr_write(ctrl_pkg::ADDR_PICMR, mask);
      spr_write(ctrl_pkg::ADDR_SR, 32'h0000_8005);
      pulse_irq(line_off);
      watch_no_branch(20, hits);
      expect_eq("masked", 32'h0, hits);
      spr_read(ctrl_pkg::ADDR_PICSR, rdata);
      expect_eq("PICSR masked", picsr_after_edge(32'h0, mask, line_off), rdata);
      pulse_irq(line_on);
      await_branch(10);
      expect_eq("vector", expected_vector(6'b010000, evba_exp), branch_pc_o);
      await_branch_end();
      spr_read(ctrl_pkg::ADDR_PICSR, rdata);
      expect_eq("PICSR", picsr_after_edge(32'h0, mask, line_on), rdata);
      spr_write(ctrl_pkg::ADDR_PICSR, 32'h1 << line_on);
      spr_read(ctrl_pkg::ADDR_PICSR, rdata);
      expect_eq("PICSR cleared", 32'h0, rdata);
      end_test();

      $display("Done: %0d tests, %0d checks, %0d errors", tests_done, checks,
               errors + other_errors);
      if (errors + other_errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* or1k_ctrl_unit.f */
+incdir+test
hdl/ctrl_pkg.sv
hdl/spr_bus_ctrl.sv
hdl/exception_ctrl.sv
hdl/sys_spr_regs.sv
hdl/tick_timer.sv
hdl/pic.sv
hdl/or1k_ctrl_unit.sv
test/tb_or1k_ctrl_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -sv -f or1k_ctrl_unit.f \
   --top-module tb_or1k_ctrl_unit -Mdir obj_dir -o tb_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "RESULT: PASS" "$SIM_LOG"; then
   exit 0
fi
exit 1
